/* hdl/clock_pkg.sv */
package clock_pkg;

	// ----------------------------------------
	// operating mode and field select
	// ----------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HR  = 2'd2
	} pos_e;

	// ----------------------------------------
	// bundles
	// ----------------------------------------
	typedef struct packed {
		logic [5:0] hr;
		logic [5:0] min;
		logic [5:0] sec;
	} hms_t;

	// press pulses, also raw active-low button levels
	typedef struct packed {
		logic mode;
		logic pos;
		logic inc;
		logic alm;
	} btn_t;

	typedef struct packed {
		logic sec;
		logic min;
		logic hr;
	} step_t;

	// ----------------------------------------
	// counting and display constants
	// ----------------------------------------
	localparam logic [5:0] SEC_MAX = 6'd59;
	localparam logic [5:0] MIN_MAX = 6'd59;
	localparam logic [5:0] HR_MAX  = 6'd23;

	localparam int NUM_DIGITS = 6;
	localparam int SEG_W      = 7;
	localparam int SCAN_W     = $clog2(NUM_DIGITS);	// scan index width

	// defaults for a 50 MHz clk
	localparam int SEC_DIV_DEF  = 50_000_000;	// 1 Hz
	localparam int SCAN_DIV_DEF = 5_000;		// 10 kHz digit rate
	localparam int DEB_DIV_DEF  = 500_000;		// 100 Hz sampling

endpackage

/* hdl/tick_gen.sv */
`timescale 1ns/100ps

module tick_gen #(
	parameter int DIV = 2
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	logic [31:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			cnt <= 32'd0;
		end else begin
			if (cnt == 32'(DIV - 1)) begin
				cnt <= 32'd0;	// terminal count, start over
			end else begin
				cnt <= cnt + 32'd1;
			end
		end
	end

	// one clk wide, on the terminal count
	assign o_tick = (cnt == 32'(DIV - 1));

endmodule

/* hdl/button_sync.sv */
`timescale 1ns/100ps

module button_sync import clock_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  btn_t i_btn,		// active low
	input  logic i_deb_tick,
	output btn_t o_press
);

	btn_t sync_q1;
	btn_t sync_q2;
	btn_t samp_new;
	btn_t samp_old;

	// ----------------------------------------
	// two-flop synchronizer
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			sync_q1 <= '1;	// idle high
			sync_q2 <= '1;
		end else begin
			sync_q1 <= i_btn;
			sync_q2 <= sync_q1;
		end
	end

	// ----------------------------------------
	// debounce samples
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			samp_new <= '1;
			samp_old <= '1;
		end else begin
			if (i_deb_tick) begin
				samp_new <= sync_q2;
				samp_old <= samp_new;
			end
		end
	end

	// falling edge between two samples -> one pulse
	// samples only move on a tick, so gating by the tick gives a single cycle
	assign o_press = i_deb_tick ? btn_t'(samp_old & ~samp_new) : '0;

endmodule

/* hdl/clock_ctrl.sv */
`timescale 1ns/100ps

module clock_ctrl import clock_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  btn_t  i_press,
	input  logic  i_sec_tick,
	output mode_e o_mode,
	output step_t o_time_step,
	output step_t o_alarm_step,
	output logic  o_run,
	output logic  o_alarm_en
);

	pos_e  pos;
	step_t sel_step;	// inc routed to the selected field

	// ----------------------------------------
	// mode, position, alarm enable
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_mode     <= MODE_CLOCK;
			pos        <= POS_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (i_press.mode) begin
				case (o_mode)
					MODE_CLOCK: o_mode <= MODE_SETUP;
					MODE_SETUP: o_mode <= MODE_ALARM;
					default:    o_mode <= MODE_CLOCK;
				endcase
			end
			if (i_press.pos) begin
				case (pos)
					POS_SEC: pos <= POS_MIN;
					POS_MIN: pos <= POS_HR;
					default: pos <= POS_SEC;
				endcase
			end
			if (i_press.alm)
				o_alarm_en <= ~o_alarm_en;	// toggle
		end
	end

	// ----------------------------------------
	// step routing
	// ----------------------------------------
	always_comb begin
		sel_step = '0;
		case (pos)
			POS_SEC: sel_step.sec = i_press.inc;
			POS_MIN: sel_step.min = i_press.inc;
			default: sel_step.hr  = i_press.inc;
		endcase
	end

	assign o_run = (o_mode != MODE_SETUP);	// time halts only in setup

	always_comb begin
		o_time_step  = '0;
		o_alarm_step = '0;
		case (o_mode)
			MODE_SETUP: o_time_step  = sel_step;
			MODE_ALARM: o_alarm_step = sel_step;
			default:    ;	// inc ignored in clock mode
		endcase
		o_time_step.sec = o_time_step.sec | (o_run & i_sec_tick);
	end

endmodule

/* hdl/hms_counter.sv */
`timescale 1ns/100ps

module hms_counter import clock_pkg::*; #(
	parameter bit CASCADE = 1'b1
) (
	input  logic  clk,
	input  logic  rst_n,
	input  step_t i_step,
	output hms_t  o_hms
);

	logic sec_wrap;
	logic min_inc;
	logic min_wrap;
	logic hr_inc;

	// next value of one field, wraps to 0 past max
	function automatic logic [5:0] next_field(
		input logic [5:0] val,
		input logic [5:0] max,
		input logic       inc
	);
		if (!inc)
			next_field = val;
		else if (val >= max)
			next_field = 6'd0;
		else
			next_field = val + 6'd1;
	endfunction

	// ----------------------------------------
	// carry chain
	// ----------------------------------------
	assign sec_wrap = i_step.sec && (o_hms.sec >= SEC_MAX);
	assign min_inc  = i_step.min || (CASCADE && sec_wrap);
	assign min_wrap = min_inc && (o_hms.min >= MIN_MAX);
	assign hr_inc   = i_step.hr || (CASCADE && min_wrap);

	// ----------------------------------------
	// registers
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_hms <= '0;	// 00:00:00
		end else begin
			o_hms.sec <= next_field(o_hms.sec, SEC_MAX, i_step.sec);
			o_hms.min <= next_field(o_hms.min, MIN_MAX, min_inc);
			o_hms.hr  <= next_field(o_hms.hr, HR_MAX, hr_inc);
		end
	end

endmodule

/* hdl/alarm_match.sv */
`timescale 1ns/100ps

module alarm_match import clock_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  hms_t i_time,
	input  hms_t i_alarm,
	input  logic i_alarm_en,
	output logic o_alarm
);

	logic match;

	assign match = (i_time == i_alarm);

	// latches on a match, cleared only when enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en & (o_alarm | match);
		end
	end

endmodule

/* hdl/seg_display.sv */
`timescale 1ns/100ps

module seg_display import clock_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_scan_tick,
	input  mode_e                 i_mode,
	input  hms_t                  i_time,
	input  hms_t                  i_alarm,
	output logic [SEG_W-1:0]      o_seg,		// {a..g}, active high
	output logic [NUM_DIGITS-1:0] o_seg_enb		// active low
);

	hms_t              shown;
	logic [3:0]        digit [NUM_DIGITS];
	logic [SCAN_W-1:0] scan_idx;

	// ----------------------------------------
	// bcd to seven segments
	// ----------------------------------------
	function automatic logic [SEG_W-1:0] seg_decode(input logic [3:0] code);
		case (code)
			4'd0:    seg_decode = 7'b111_1110;
			4'd1:    seg_decode = 7'b011_0000;
			4'd2:    seg_decode = 7'b110_1101;
			4'd3:    seg_decode = 7'b111_1001;
			4'd4:    seg_decode = 7'b011_0011;
			4'd5:    seg_decode = 7'b101_1011;
			4'd6:    seg_decode = 7'b101_1111;
			4'd7:    seg_decode = 7'b111_0000;
			4'd8:    seg_decode = 7'b111_1111;
			4'd9:    seg_decode = 7'b111_0011;
			default: seg_decode = 7'b000_0000;	// blank
		endcase
	endfunction

	function automatic logic [3:0] tens(input logic [5:0] val);
		tens = 4'(val / 6'd10);
	endfunction

	function automatic logic [3:0] ones(input logic [5:0] val);
		ones = 4'(val % 6'd10);
	endfunction

	// ----------------------------------------
	// source select and digit split
	// ----------------------------------------
	assign shown = (i_mode == MODE_ALARM) ? i_alarm : i_time;

	always_comb begin
		digit[0] = ones(shown.sec);
		digit[1] = tens(shown.sec);
		digit[2] = ones(shown.min);
		digit[3] = tens(shown.min);
		digit[4] = ones(shown.hr);
		digit[5] = tens(shown.hr);
	end

	// ----------------------------------------
	// scan
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			scan_idx <= '0;
		end else begin
			if (i_scan_tick) begin
				if (scan_idx == SCAN_W'(NUM_DIGITS - 1))
					scan_idx <= '0;
				else
					scan_idx <= scan_idx + 1'b1;
			end
		end
	end

	assign o_seg     = seg_decode(digit[scan_idx]);
	assign o_seg_enb = ~(NUM_DIGITS'(1) << scan_idx);	// one low bit

endmodule

/* hdl/digital_clock.sv */
`timescale 1ns/100ps

module digital_clock import clock_pkg::*; #(
	parameter int SEC_DIV  = SEC_DIV_DEF,
	parameter int SCAN_DIV = SCAN_DIV_DEF,
	parameter int DEB_DIV  = DEB_DIV_DEF
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  btn_t                  i_btn,
	output logic [SEG_W-1:0]      o_seg,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	output logic                  o_alarm
);

	logic  sec_tick;
	logic  scan_tick;
	logic  deb_tick;
	btn_t  press;
	mode_e mode;
	step_t time_step;
	step_t alarm_step;
	logic  alarm_en;
	hms_t  time_hms;
	hms_t  alarm_hms;

	// ----------------------------------------
	// tick sources
	// ----------------------------------------
	tick_gen #(.DIV(SEC_DIV))  u_sec_tick  (.clk(clk), .rst_n(rst_n), .o_tick(sec_tick));
	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (.clk(clk), .rst_n(rst_n), .o_tick(scan_tick));
	tick_gen #(.DIV(DEB_DIV))  u_deb_tick  (.clk(clk), .rst_n(rst_n), .o_tick(deb_tick));

	// ----------------------------------------
	// buttons and control
	// ----------------------------------------
	button_sync u_button_sync (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_btn      (i_btn),
		.i_deb_tick (deb_tick),
		.o_press    (press)
	);

	clock_ctrl u_clock_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_press      (press),
		.i_sec_tick   (sec_tick),
		.o_mode       (mode),
		.o_time_step  (time_step),
		.o_alarm_step (alarm_step),
		.o_run        (),		// consumed inside the controller
		.o_alarm_en   (alarm_en)
	);

	// ----------------------------------------
	// time, alarm, display
	// ----------------------------------------
	hms_counter #(.CASCADE(1'b1)) u_time  (.clk(clk), .rst_n(rst_n), .i_step(time_step),
		.o_hms(time_hms));
	hms_counter #(.CASCADE(1'b0)) u_alarm (.clk(clk), .rst_n(rst_n), .i_step(alarm_step),
		.o_hms(alarm_hms));

	alarm_match u_alarm_match (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_time     (time_hms),
		.i_alarm    (alarm_hms),
		.i_alarm_en (alarm_en),
		.o_alarm    (o_alarm)
	);

	seg_display u_seg_display (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_mode      (mode),
		.i_time      (time_hms),
		.i_alarm     (alarm_hms),
		.o_seg       (o_seg),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

/* sim/tb_digital_clock.sv */
`timescale 1ns/100ps

module tb_digital_clock import clock_pkg::*; ();

	localparam int SEC_DIV   = 40;
	localparam int HOLD      = 12;	// cycles low, then cycles high, per press
	localparam int MAX_PRESS = 90;
	localparam int TEST_LEN  = 10 + 62 * SEC_DIV + MAX_PRESS * (2 * HOLD + SEC_DIV)
		+ 96 * SEC_DIV;
	localparam int WATCHDOG  = TEST_LEN + TEST_LEN / 5;	// 20% margin

	localparam btn_t MODE_BTN = 4'b1000;
	localparam btn_t POS_BTN  = 4'b0100;
	localparam btn_t INC_BTN  = 4'b0010;
	localparam btn_t ALM_BTN  = 4'b0001;

	logic                  clk;
	logic                  rst_n;
	btn_t                  btn;
	logic [SEG_W-1:0]      o_seg;
	logic [NUM_DIGITS-1:0] o_seg_enb;
	logic                  o_alarm;

	// reference model state
	hms_t  m_time   = '0;
	hms_t  m_alm    = '0;
	mode_e m_mode   = MODE_CLOCK;
	pos_e  m_pos    = POS_SEC;
	bit    m_en     = 1'b0;
	bit    m_alarm  = 1'b0;
	int    cyc      = 0;	// clk edges seen out of reset
	bit    counting = 1'b0;
	bit    settling = 1'b0;	// a press is in flight
	int    skip     = 0;

	bit               cap_one;
	int               cap_idx;
	int               cap_digit;
	logic [SEG_W-1:0] exp_seg;

	digital_clock #(.SEC_DIV(SEC_DIV), .SCAN_DIV(2), .DEB_DIV(3)) u_digital_clock (
		.clk(clk), .rst_n(rst_n), .i_btn(btn), .o_seg(o_seg), .o_seg_enb(o_seg_enb),
		.o_alarm(o_alarm)
	);

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic logic [SEG_W-1:0] seg_pattern(input int d);
		case (d)	// {a..g}
			0:       return 7'h7e;
			1:       return 7'h30;
			2:       return 7'h6d;
			3:       return 7'h79;
			4:       return 7'h33;
			5:       return 7'h5b;
			6:       return 7'h5f;
			7:       return 7'h70;
			8:       return 7'h7f;
			9:       return 7'h73;
			default: return 7'h00;
		endcase
	endfunction

	function automatic int seg_to_digit(input logic [SEG_W-1:0] s);
		for (int d = 0; d < 10; d++)
			if (seg_pattern(d) == s)
				return d;
		return 15;	// not a digit
	endfunction

	// expected segments of one scan digit
	function automatic logic [SEG_W-1:0] ref_seg(input int idx, input hms_t t,
		input hms_t a, input mode_e md);
		hms_t src;
		int   field;
		src = (md == MODE_ALARM) ? a : t;
		case (idx / 2)
			0:       field = src.sec;
			1:       field = src.min;
			default: field = src.hr;
		endcase
		return seg_pattern((idx % 2 == 0) ? field % 10 : field / 10);
	endfunction

	// one step of a field with wrap, carry into higher fields if asked
	function automatic hms_t step_hms(input hms_t t, input pos_e p, input bit carry);
		bit do_min;
		bit do_hr;
		do_min = (p == POS_MIN);
		do_hr  = (p == POS_HR);
		if (p == POS_SEC) begin
			do_min = carry && (t.sec == SEC_MAX);
			t.sec  = (t.sec == SEC_MAX) ? 6'd0 : t.sec + 6'd1;
		end
		if (do_min) begin
			do_hr = do_hr || (carry && (t.min == MIN_MAX));
			t.min = (t.min == MIN_MAX) ? 6'd0 : t.min + 6'd1;
		end
		if (do_hr)
			t.hr = (t.hr == HR_MAX) ? 6'd0 : t.hr + 6'd1;
		return t;
	endfunction

	task automatic apply_press(input btn_t mask);
		if (mask.mode)
			m_mode = (m_mode == MODE_CLOCK) ? MODE_SETUP :
				(m_mode == MODE_SETUP) ? MODE_ALARM : MODE_CLOCK;
		if (mask.pos)
			m_pos = (m_pos == POS_SEC) ? POS_MIN : (m_pos == POS_MIN) ? POS_HR : POS_SEC;
		if (mask.alm)
			m_en = !m_en;
		if (mask.inc && m_mode == MODE_SETUP)
			m_time = step_hms(m_time, m_pos, 1'b1);
		else if (mask.inc && m_mode == MODE_ALARM)
			m_alm = step_hms(m_alm, m_pos, 1'b0);
	endtask

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// hold buttons low, then release and stay idle
	task automatic press(input btn_t mask, input bit align);
		if (align) begin
			do
				@(posedge clk);
			while (cyc % SEC_DIV != 1);	// just past a second tick
		end else begin
			@(posedge clk);
		end
		settling = 1'b1;
		btn <= ~mask;
		repeat (HOLD) @(posedge clk);
		btn <= '1;
		apply_press(mask);	// DUT has acted on the press by now
		skip     = 2;
		settling = 1'b0;
		repeat (HOLD) @(posedge clk);
	endtask

	// ----------------------------------------
	// clock, watchdog, capture, compare
	// ----------------------------------------
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG) @(posedge clk);
		fail_run($sformatf("timeout, test still running after %0d cycles", WATCHDOG));
	end

	always_comb begin
		int lows;
		lows    = 0;
		cap_idx = 0;
		for (int k = 0; k < NUM_DIGITS; k++) begin
			if (o_seg_enb[k] == 1'b0) begin
				lows++;
				cap_idx = k;
			end
		end
		cap_one   = (lows == 1);
		cap_digit = seg_to_digit(o_seg);
	end

	// model steps on the falling edge, outputs are stable here
	always @(negedge clk) begin
		if (counting) begin
			cyc++;
			// flag follows pre-edge time
			if (!m_en)
				m_alarm = 1'b0;
			else if (m_time == m_alm)
				m_alarm = 1'b1;
			if (cyc % SEC_DIV == 0 && m_mode != MODE_SETUP) begin
				m_time = step_hms(m_time, POS_SEC, 1'b1);
				skip   = 1;
			end
		end
		counting = rst_n;
		if (skip > 0) begin
			skip--;
		end else if (counting && !settling) begin
			exp_seg = ref_seg(cap_idx, m_time, m_alm, m_mode);
			assert (cap_one) else fail_run("o_seg_enb does not select exactly one digit");
			assert (o_seg == exp_seg) else fail_run($sformatf(
				"ERR o_seg digit %0d exp %h got %h (reads %0d)", cap_idx, exp_seg, o_seg,
				cap_digit));
			assert (o_alarm == m_alarm) else fail_run($sformatf(
				"ERR o_alarm exp %h got %h", m_alarm, o_alarm));
		end
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin
		int n;
		void'($urandom(2753));
		btn   = '1;	// buttons idle high
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (o_seg_enb == 6'h3e) else fail_run($sformatf(
			"ERR o_seg_enb exp 3e got %h", o_seg_enb));
		assert (o_seg == seg_pattern(0)) else fail_run($sformatf(
			"ERR o_seg exp %h got %h", seg_pattern(0), o_seg));
		@(posedge clk);
		while (!(m_time.min == 6'd1 && m_time.sec == 6'd1))	// through 59 -> 00
			@(posedge clk);
		press(MODE_BTN, 1'b1);	// setup, time frozen
		repeat (3 * SEC_DIV) @(posedge clk);
		n = 1 + $urandom % 6;
		repeat (n) press(INC_BTN, 1'b0);
		press(POS_BTN, 1'b0);
		n = 1 + $urandom % 6;
		repeat (n) press(INC_BTN, 1'b0);
		press(POS_BTN, 1'b0);
		n = 24 + $urandom % 4;	// hours always wrap
		repeat (n) press(INC_BTN, 1'b0);
		press(POS_BTN, 1'b0);
		press(MODE_BTN, 1'b1);	// alarm mode, time runs again
		n = 20 + $urandom % 6;
		repeat (n) press(INC_BTN, 1'b0);
		press(POS_BTN, 1'b0);
		while (m_alm.min != (m_time.min + 6'd1) % 60)
			press(INC_BTN, 1'b0);
		press(POS_BTN, 1'b0);
		while (m_alm.hr != m_time.hr)
			press(INC_BTN, 1'b0);
		press(MODE_BTN, 1'b1);
		press(ALM_BTN, 1'b1);	// enable, alarm lies ahead of time
		while (!m_alarm)
			@(posedge clk);
		repeat (2 * SEC_DIV) @(posedge clk);
		@(negedge clk);
		assert (o_alarm == 1'b1) else fail_run($sformatf("ERR o_alarm exp 1 got %h", o_alarm));
		press(ALM_BTN, 1'b1);
		repeat (4) @(negedge clk);
		assert (o_alarm == 1'b0) else fail_run($sformatf("ERR o_alarm exp 0 got %h", o_alarm));
		$display("Test OK");
		$finish;
	end

endmodule

/* files.f */
hdl/clock_pkg.sv
hdl/tick_gen.sv
hdl/button_sync.sv
hdl/clock_ctrl.sv
hdl/hms_counter.sv
hdl/alarm_match.sv
hdl/seg_display.sv
hdl/digital_clock.sv
sim/tb_digital_clock.sv
